// File: files.f
hdl/wb_bus_pkg.sv
hdl/mips_isa_pkg.sv
hdl/wb_req_if.sv
hdl/reg_file.sv
hdl/inst_fetch.sv
hdl/exec_core.sv
hdl/wb_arbiter.sv
hdl/openmips_lite.sv
test/tb_clock.sv
test/openmips_lite_checker.sv
test/openmips_lite_tb.sv

// File: hdl/exec_core.sv
`timescale 1ns/100ps
module exec_core (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                inst_valid_i,
	input  mips_isa_pkg::inst_t inst_i,
	output logic                inst_ready_o,
	wb_req_if.master            bus_m
);
	import wb_bus_pkg::*;
	import mips_isa_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_ALU, S_MEM} state_t;

	state_t   state_q;
	inst_t    inst_q;
	logic     accept;
	logic     is_mem;
	word_t    rs_val;
	word_t    rt_val;
	word_t    imm_sext;
	word_t    imm_zext;
	word_t    alu_res;
	logic     alu_we;
	reg_idx_t alu_dst;
	logic     rf_we;
	reg_idx_t rf_waddr;
	word_t    rf_wdata;

	assign inst_ready_o = (state_q == S_IDLE);
	assign accept       = inst_valid_i && inst_ready_o;
	assign is_mem       = (inst_i.i.opcode == OP_LW) || (inst_i.i.opcode == OP_SW);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (accept)
						state_q <= is_mem ? S_MEM : S_ALU;
				end
				S_ALU: state_q <= S_IDLE;
				S_MEM: begin
					if (bus_m.ack)
						state_q <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			inst_q <= inst_i;
	end

	assign imm_sext = {{16{inst_q.i.imm[15]}}, inst_q.i.imm};
	assign imm_zext = {16'h0000, inst_q.i.imm};

	always_comb begin
		alu_res = '0;
		alu_we  = 1'b1;
		alu_dst = inst_q.i.rt;
		case (inst_q.i.opcode)
			OP_SPECIAL: begin
				alu_dst = inst_q.r.rd;
				case (inst_q.r.funct)
					FN_ADDU: alu_res = rs_val + rt_val;
					FN_SUBU: alu_res = rs_val - rt_val;
					FN_AND:  alu_res = rs_val & rt_val;
					FN_OR:   alu_res = rs_val | rt_val;
					FN_XOR:  alu_res = rs_val ^ rt_val;
					FN_SLT:  alu_res = {31'b0, $signed(rs_val) < $signed(rt_val)};
					FN_SLL:  alu_res = rt_val << inst_q.r.shamt;
					FN_SRL:  alu_res = rt_val >> inst_q.r.shamt;
					default: alu_we  = 1'b0;
				endcase
			end
			OP_ADDIU: alu_res = rs_val + imm_sext;
			OP_ANDI:  alu_res = rs_val & imm_zext;
			OP_ORI:   alu_res = rs_val | imm_zext;
			OP_XORI:  alu_res = rs_val ^ imm_zext;
			OP_LUI:   alu_res = {inst_q.i.imm, 16'h0000};
			// unknown words retire as nops
			default:  alu_we  = 1'b0;
		endcase
	end

	// loads write back on the ack
	assign rf_we    = (state_q == S_ALU && alu_we) ||
	                  (state_q == S_MEM && bus_m.ack && !bus_m.we);
	assign rf_waddr = (state_q == S_MEM) ? inst_q.i.rt : alu_dst;
	assign rf_wdata = (state_q == S_MEM) ? bus_m.rdata : alu_res;

	assign bus_m.stb   = (state_q == S_MEM);
	assign bus_m.we    = (inst_q.i.opcode == OP_SW);
	assign bus_m.addr  = rs_val + imm_sext;
	assign bus_m.wdata = rt_val;
	assign bus_m.sel   = '1;

	reg_file u_reg_file (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.raddr1_i (inst_q.i.rs),
		.raddr2_i (inst_q.i.rt),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata),
		.rdata1_o (rs_val),
		.rdata2_o (rt_val)
	);

endmodule

// File: hdl/inst_fetch.sv
`timescale 1ns/100ps
module inst_fetch #(
	parameter wb_bus_pkg::addr_t RESET_PC = wb_bus_pkg::DEFAULT_RESET_PC
) (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                inst_ready_i,
	output logic                inst_valid_o,
	output mips_isa_pkg::inst_t inst_o,
	wb_req_if.master            bus_m
);
	import wb_bus_pkg::*;
	import mips_isa_pkg::*;

	typedef enum logic {S_FETCH, S_VALID} state_t;

	state_t state_q;
	addr_t  pc_q;
	inst_t  inst_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_FETCH;
			pc_q    <= RESET_PC;
		end else begin
			case (state_q)
				S_FETCH: begin
					if (bus_m.ack)
						state_q <= S_VALID;
				end
				S_VALID: begin
					// handshake, move on to the next word
					if (inst_ready_i) begin
						state_q <= S_FETCH;
						pc_q    <= pc_q + 32'd4;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_FETCH && bus_m.ack)
			inst_q <= bus_m.rdata;
	end

	assign bus_m.stb   = (state_q == S_FETCH);
	assign bus_m.we    = 1'b0;
	assign bus_m.addr  = pc_q;
	assign bus_m.wdata = '0;
	assign bus_m.sel   = '1;

	assign inst_valid_o = (state_q == S_VALID);
	assign inst_o       = inst_q;

endmodule

// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

	typedef logic [4:0] reg_idx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// major opcodes
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;
	localparam opcode_t OP_LW      = 6'b100011;
	localparam opcode_t OP_SW      = 6'b101011;

	// function codes under OP_SPECIAL
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_SLT  = 6'b101010;

	typedef struct packed {
		opcode_t    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_t     opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
	} i_fmt_t;

	// one fetched word, seen as R or I format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} inst_t;

endpackage

// File: hdl/openmips_lite.sv
`timescale 1ns/100ps
module openmips_lite #(
	parameter wb_bus_pkg::addr_t RESET_PC = wb_bus_pkg::DEFAULT_RESET_PC
) (
	input  logic              clk,
	input  logic              arst_n_i,
	input  wb_bus_pkg::word_t wishbone_data_i,
	input  logic              wishbone_ack_i,
	output wb_bus_pkg::addr_t wishbone_addr_o,
	output wb_bus_pkg::word_t wishbone_data_o,
	output logic              wishbone_we_o,
	output wb_bus_pkg::sel_t  wishbone_select_o,
	output logic              wishbone_stb_o,
	output logic              wishbone_cyc_o
);
	import mips_isa_pkg::*;

	logic  inst_valid;
	logic  inst_ready;
	inst_t inst;

	wb_req_if fetch_bus ();
	wb_req_if data_bus ();

	inst_fetch #(
		.RESET_PC (RESET_PC)
	) u_inst_fetch (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.inst_ready_i (inst_ready),
		.inst_valid_o (inst_valid),
		.inst_o       (inst),
		.bus_m        (fetch_bus.master)
	);

	exec_core u_exec_core (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid),
		.inst_i       (inst),
		.inst_ready_o (inst_ready),
		.bus_m        (data_bus.master)
	);

	// one external master port shared by fetch and load/store
	wb_arbiter u_wb_arbiter (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.fetch_s   (fetch_bus.slave),
		.data_s    (data_bus.slave),
		.wb_addr_o (wishbone_addr_o),
		.wb_data_o (wishbone_data_o),
		.wb_we_o   (wishbone_we_o),
		.wb_sel_o  (wishbone_select_o),
		.wb_stb_o  (wishbone_stb_o),
		.wb_cyc_o  (wishbone_cyc_o),
		.wb_data_i (wishbone_data_i),
		.wb_ack_i  (wishbone_ack_i)
	);

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/100ps
module reg_file (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  mips_isa_pkg::reg_idx_t raddr1_i,
	input  mips_isa_pkg::reg_idx_t raddr2_i,
	input  logic                   we_i,
	input  mips_isa_pkg::reg_idx_t waddr_i,
	input  wb_bus_pkg::word_t      wdata_i,
	output wb_bus_pkg::word_t      rdata1_o,
	output wb_bus_pkg::word_t      rdata2_o
);
	import wb_bus_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// r0 is hardwired
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: hdl/wb_arbiter.sv
`timescale 1ns/100ps
module wb_arbiter (
	input  logic              clk,
	input  logic              arst_n_i,
	wb_req_if.slave           fetch_s,
	wb_req_if.slave           data_s,
	output wb_bus_pkg::addr_t wb_addr_o,
	output wb_bus_pkg::word_t wb_data_o,
	output logic              wb_we_o,
	output wb_bus_pkg::sel_t  wb_sel_o,
	output logic              wb_stb_o,
	output logic              wb_cyc_o,
	input  wb_bus_pkg::word_t wb_data_i,
	input  logic              wb_ack_i
);
	typedef enum logic [1:0] {G_NONE, G_FETCH, G_DATA} grant_t;

	grant_t grant_q;
	logic   data_own;
	logic   fetch_own;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			grant_q <= G_NONE;
		end else if (grant_q == G_NONE) begin
			// data wins a tie
			if (data_s.stb)
				grant_q <= G_DATA;
			else if (fetch_s.stb)
				grant_q <= G_FETCH;
		end else if (wb_ack_i && wb_stb_o) begin
			grant_q <= G_NONE;
		end
	end

	assign data_own  = (grant_q == G_DATA);
	assign fetch_own = (grant_q == G_FETCH);

	assign wb_stb_o  = (data_own && data_s.stb) || (fetch_own && fetch_s.stb);
	assign wb_cyc_o  = wb_stb_o;
	assign wb_we_o   = data_own ? data_s.we : 1'b0;
	assign wb_addr_o = data_own ? data_s.addr : fetch_s.addr;
	assign wb_data_o = data_own ? data_s.wdata : fetch_s.wdata;
	assign wb_sel_o  = data_own ? data_s.sel : fetch_s.sel;

	assign data_s.ack    = data_own && wb_ack_i;
	assign data_s.rdata  = data_own ? wb_data_i : '0;
	assign fetch_s.ack   = fetch_own && wb_ack_i;
	assign fetch_s.rdata = fetch_own ? wb_data_i : '0;

endmodule

// File: hdl/wb_bus_pkg.sv
package wb_bus_pkg;

	// bus data word, also the register width
	typedef logic [31:0] word_t;

	// byte address
	typedef logic [31:0] addr_t;

	// one bit per byte lane
	typedef logic [3:0] sel_t;

	localparam addr_t DEFAULT_RESET_PC = 32'h0000_0000;

endpackage

// File: hdl/wb_req_if.sv
`timescale 1ns/100ps
interface wb_req_if;
	import wb_bus_pkg::*;

	logic  stb;
	logic  we;
	addr_t addr;
	word_t wdata;
	sel_t  sel;
	word_t rdata;
	logic  ack;

	// request held until stb && ack
	modport master (output stb, we, addr, wdata, sel, input rdata, ack);
	modport slave (input stb, we, addr, wdata, sel, output rdata, ack);

endinterface

// File: test/openmips_lite_checker.sv
`timescale 1ns/100ps
module openmips_lite_checker (
	input logic              clk,
	input logic              arst_n_i,
	input logic              wishbone_stb_o,
	input logic              wishbone_cyc_o,
	input logic              wishbone_we_o,
	input logic              wishbone_ack_i,
	input wb_bus_pkg::addr_t wishbone_addr_o,
	input wb_bus_pkg::word_t wishbone_data_o,
	input wb_bus_pkg::sel_t  wishbone_select_o
);
	int unsigned fail_count = 0;

	a_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
		wishbone_stb_o |-> wishbone_cyc_o)
		else begin
			$error("stb high without cyc");
			fail_count++;
		end

	// request fields frozen while waiting for ack
	a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
		wishbone_stb_o && !wishbone_ack_i |=> $stable(wishbone_addr_o) && $stable(wishbone_we_o)
			&& $stable(wishbone_data_o) && $stable(wishbone_select_o))
		else begin
			$error("request changed before ack");
			fail_count++;
		end

	a_sel_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		wishbone_stb_o |-> wishbone_select_o == 4'hf)
		else begin
			$error("select is not all four lanes");
			fail_count++;
		end

endmodule

bind openmips_lite openmips_lite_checker u_checker (.*);

// File: test/openmips_lite_tb.sv
`timescale 1ns/100ps
module openmips_lite_tb;
	import wb_bus_pkg::*;
	import mips_isa_pkg::*;

	localparam addr_t RESET_PC  = DEFAULT_RESET_PC;
	localparam int    MEM_WORDS = 1024;
	localparam int    DATA_BASE = 32'h800;
	localparam int    DUMP_BASE = 32'hc00;

	logic  clk;
	logic  arst_n_i;
	word_t wishbone_data_i;
	logic  wishbone_ack_i;
	addr_t wishbone_addr_o;
	word_t wishbone_data_o;
	logic  wishbone_we_o;
	sel_t  wishbone_select_o;
	logic  wishbone_stb_o;
	logic  wishbone_cyc_o;

	word_t       mem [MEM_WORDS];
	word_t       model_mem [MEM_WORDS];
	word_t       model_regs [32];
	logic [31:0] lfsr_state = 32'h85140a0f;
	addr_t       exp_addr [$];
	word_t       exp_data [$];
	addr_t       got_addr [$];
	word_t       got_data [$];
	addr_t       fetch_q [$];
	int          prog_len = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          wait_left = -1;
	int          n;
	int          mark;
	int          body_stores;
	bit          timed_out = 1'b0;

	tb_clock u_tb_clock (.clk_o(clk));

	openmips_lite #(
		.RESET_PC (RESET_PC)
	) u_openmips_lite (.*);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] v;
		int          k;
		v = '0;
		for (k = 0; k < count; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'(rand_bits(5));
	endfunction

	function automatic logic [15:0] rand16();
		return 16'(rand_bits(16));
	endfunction

	function automatic word_t fill_word(input int idx);
		return ({idx[29:0], 2'b00} * 32'h9e37_79b1) ^ 32'h3c6e_f372;
	endfunction

	function automatic inst_t r_word(input funct_t fn, input reg_idx_t rs, input reg_idx_t rt,
			input reg_idx_t rd, input logic [4:0] sh);
		inst_t w;
		w.r = '{opcode: OP_SPECIAL, rs: rs, rt: rt, rd: rd, shamt: sh, funct: fn};
		return w;
	endfunction

	function automatic inst_t i_word(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
			input logic [15:0] imm);
		inst_t w;
		w.i = '{opcode: op, rs: rs, rt: rt, imm: imm};
		return w;
	endfunction

	task automatic model_write(input reg_idx_t idx, input word_t v);
		if (idx != 5'd0)
			model_regs[idx] = v;
	endtask

	// architectural effect of one instruction
	task automatic model_exec(input inst_t w);
		word_t a;
		word_t b;
		word_t se;
		word_t ze;
		word_t ea;
		a  = model_regs[w.i.rs];
		b  = model_regs[w.i.rt];
		se = {{16{w.i.imm[15]}}, w.i.imm};
		ze = {16'h0000, w.i.imm};
		ea = a + se;
		case (w.i.opcode)
			OP_SPECIAL: begin
				case (w.r.funct)
					FN_ADDU: model_write(w.r.rd, a + b);
					FN_SUBU: model_write(w.r.rd, a - b);
					FN_AND:  model_write(w.r.rd, a & b);
					FN_OR:   model_write(w.r.rd, a | b);
					FN_XOR:  model_write(w.r.rd, a ^ b);
					FN_SLT:  model_write(w.r.rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					FN_SLL:  model_write(w.r.rd, b << w.r.shamt);
					FN_SRL:  model_write(w.r.rd, b >> w.r.shamt);
					default: ;
				endcase
			end
			OP_ADDIU: model_write(w.i.rt, a + se);
			OP_ANDI:  model_write(w.i.rt, a & ze);
			OP_ORI:   model_write(w.i.rt, a | ze);
			OP_XORI:  model_write(w.i.rt, a ^ ze);
			OP_LUI:   model_write(w.i.rt, ze << 16);
			OP_LW:    model_write(w.i.rt, model_mem[ea[11:2]]);
			OP_SW: begin
				model_mem[ea[11:2]] = b;
				exp_addr.push_back(ea);
				exp_data.push_back(b);
			end
			default: ;
		endcase
	endtask

	task automatic emit(input inst_t w);
		mem[(RESET_PC >> 2) + prog_len] = w;
		prog_len++;
		model_exec(w);
	endtask

	task automatic build_program();
		logic [3:0]  kind;
		logic [15:0] off;
		funct_t      fn;
		opcode_t     op;
		reg_idx_t    r;
		int          k;
		for (k = 1; k < 32; k++)
			emit(i_word(OP_ORI, 5'd0, reg_idx_t'(k), rand16()));
		for (k = 0; k < 64; k++) begin
			kind = 4'(rand_bits(4));
			off  = 16'(DATA_BASE + rand_bits(6) * 4);
			if (kind < 4'd8) begin
				case (rand_bits(3))
					0: fn = FN_ADDU;
					1: fn = FN_SUBU;
					2: fn = FN_AND;
					3: fn = FN_OR;
					4: fn = FN_XOR;
					5: fn = FN_SLT;
					6: fn = FN_SLL;
					default: fn = FN_SRL;
				endcase
				r = (fn == FN_SLL || fn == FN_SRL) ? rand_reg() : 5'd0;
				emit(r_word(fn, rand_reg(), rand_reg(), rand_reg(), r));
			end else if (kind < 4'd13) begin
				case (rand_bits(3))
					1: op = OP_ANDI;
					2: op = OP_ORI;
					3: op = OP_XORI;
					4: op = OP_LUI;
					default: op = OP_ADDIU;
				endcase
				r = (op == OP_LUI) ? 5'd0 : rand_reg();
				emit(i_word(op, r, rand_reg(), rand16()));
			end else if (kind == 4'd13) begin
				emit(i_word(OP_SW, 5'd0, rand_reg(), off));
			end else if (kind == 4'd14) begin
				emit(i_word(OP_LW, 5'd0, rand_reg(), off));
			end else begin
				// store then reload the same word
				r = rand_reg();
				emit(i_word(OP_SW, 5'd0, r, off));
				emit(i_word(OP_LW, 5'd0, r + 5'd1, off));
			end
		end
		for (k = 0; k < 32; k++)
			emit(i_word(OP_SW, 5'd0, reg_idx_t'(k), 16'(DUMP_BASE + k * 4)));
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: time %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report(input string name, input int start_errors);
		tests++;
		$display("test %s: %0d errors", name, errors - start_errors);
	endtask

	// memory slave with 0 to 3 wait cycles per transfer
	always @(posedge clk) begin
		if (wishbone_ack_i) begin
			wishbone_ack_i <= 1'b0;
		end else if (arst_n_i && wishbone_stb_o) begin
			if (wait_left < 0)
				wait_left = int'(rand_bits(2));
			if (wait_left == 0) begin
				wishbone_ack_i <= 1'b1;
				if (wishbone_we_o) begin
					mem[wishbone_addr_o[11:2]] = wishbone_data_o;
					got_addr.push_back(wishbone_addr_o);
					got_data.push_back(wishbone_data_o);
				end else begin
					wishbone_data_i <= mem[wishbone_addr_o[11:2]];
					if (wishbone_addr_o < DATA_BASE)
						fetch_q.push_back(wishbone_addr_o);
				end
				wait_left = -1;
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

	initial begin
		arst_n_i        = 1'b0;
		wishbone_ack_i  = 1'b0;
		wishbone_data_i = '0;
		for (n = 0; n < MEM_WORDS; n++) begin
			mem[n]       = fill_word(n);
			model_mem[n] = mem[n];
		end
		for (n = 0; n < 32; n++)
			model_regs[n] = '0;
		build_program();

		mark = errors;
		@(posedge clk);
		repeat (10) begin
			@(negedge clk);
			compare("wishbone_stb_o", wishbone_stb_o, 1'b0);
			compare("wishbone_cyc_o", wishbone_cyc_o, 1'b0);
			compare("wishbone_we_o", wishbone_we_o, 1'b0);
		end
		@(posedge clk);
		arst_n_i <= 1'b1;
		@(negedge clk);
		n = 0;
		while (!wishbone_stb_o && n < 20) begin
			compare("wishbone_cyc_o", wishbone_cyc_o, 1'b0);
			compare("wishbone_we_o", wishbone_we_o, 1'b0);
			@(negedge clk);
			n++;
		end
		if (wishbone_stb_o) begin
			compare("wishbone_addr_o", wishbone_addr_o, RESET_PC);
			compare("wishbone_we_o", wishbone_we_o, 1'b0);
		end else begin
			$display("timeout: no bus request after reset");
			timed_out = 1'b1;
		end
		report("reset and first fetch", mark);

		n = 0;
		while (!timed_out && got_addr.size() < exp_addr.size() && n < 20000) begin
			@(negedge clk);
			n++;
		end
		if (!timed_out && got_addr.size() < exp_addr.size()) begin
			$display("timeout: only %0d of %0d stores seen", got_addr.size(), exp_addr.size());
			timed_out = 1'b1;
		end

		if (!timed_out) begin
			mark = errors;
			if (fetch_q.size() < prog_len) begin
				$display("only %0d of %0d instructions were fetched", fetch_q.size(), prog_len);
				errors++;
			end
			foreach (fetch_q[i])
				compare("wishbone_addr_o", fetch_q[i], RESET_PC + 4 * i);
			report("sequential fetch", mark);

			mark = errors;
			body_stores = exp_addr.size() - 32;
			for (n = 0; n < body_stores; n++) begin
				compare("wishbone_addr_o", got_addr[n], exp_addr[n]);
				compare("wishbone_data_o", got_data[n], exp_data[n]);
			end
			report("program stores", mark);

			mark = errors;
			for (n = 0; n < 32; n++) begin
				compare($sformatf("r%0d address", n), got_addr[body_stores + n],
					exp_addr[body_stores + n]);
				compare($sformatf("r%0d", n), got_data[body_stores + n], exp_data[body_stores + n]);
			end
			report("register dump", mark);
		end

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
			errors, u_openmips_lite.u_checker.fail_count);
		if (errors == 0 && !timed_out && u_openmips_lite.u_checker.fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps
module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);
	initial clk_o = 1'b0;

	// half a period per phase
	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule
